// ==== files.f ====
rtl/gt_bringup_pkg.sv
rtl/cdr_lock_filter.sv
rtl/rx_phalign_detect.sv
rtl/tx_phase_check.sv
rtl/align_word_codec.sv
rtl/bringup_sequencer.sv
rtl/gt_bringup_top.sv
verif/gt_bringup_assertions.sv
verif/gt_bringup_tb.sv

// ==== verif/gt_bringup_tb.sv ====
`timescale 1ns/1ps

module gt_bringup_tb
	import gt_bringup_pkg::*;
;

	localparam int WAIT_MAX = 5000; // cycles per wait

	logic               clk;
	logic               reset;
	gt_status_t         status;
	logic               mmcm_locked_i;
	logic               sfp_los_i;
	logic               txphase_stb_i;
	logic               bypass_txph_check_i;
	logic [15:0]        txphase_i;
	logic [PHASE_W-1:0] txphase_target_i;
	symbol_t            rx_sym_i;
	symbol_t            user_sym_i;
	gt_reset_t          gt_reset_o;
	symbol_t            tx_sym_o;
	logic               link_up_o;
	logic [15:0]        attempt_cnt_o;

	integer seed;
	int     val_err;
	int     other_err;
	int     rise_cnt;     // cpll_reset rises since the last link up
	logic   cpll_prev;
	logic   hold_lock_low;
	logic   dly_prev;
	int     lock_dly, tx_dly, rx_dly, ph_step, stb_cnt;

	gt_bringup_top #(
		.WAIT_CYCLES       (8),
		.TIMEOUT_SHORT     (400),
		.TIMEOUT_LONG      (600),
		.CDR_STABLE_CYCLES (16),
		.ALIGN_HOLD        (6),
		.LOCK_MAX          (3)
	) u_gt_bringup_top (
		.clk                 (clk),
		.reset               (reset),
		.gt_status_i         (status),
		.mmcm_locked_i       (mmcm_locked_i),
		.sfp_los_i           (sfp_los_i),
		.txphase_stb_i       (txphase_stb_i),
		.bypass_txph_check_i (bypass_txph_check_i),
		.txphase_i           (txphase_i),
		.txphase_target_i    (txphase_target_i),
		.rx_sym_i            (rx_sym_i),
		.user_sym_i          (user_sym_i),
		.gt_reset_o          (gt_reset_o),
		.tx_sym_o            (tx_sym_o),
		.link_up_o           (link_up_o),
		.attempt_cnt_o       (attempt_cnt_o)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// reference: low 14 bits times five, keep bits 16..12
	function automatic logic [PHASE_W-1:0] scaled_phase(input logic [15:0] p);
		int v;
		v = (p % 16384) * 5;
		v = v / 4096;
		return v[PHASE_W-1:0];
	endfunction

	function automatic symbol_t rand_sym();
		symbol_t s;
		s.data    = $random(seed);
		s.charisk = $random(seed);
		return s;
	endfunction

	// transceiver model, reacts to the reset outputs
	always @(posedge clk) begin
		#1;
		if (gt_reset_o.cpll_reset && !cpll_prev)
			rise_cnt++;
		cpll_prev = gt_reset_o.cpll_reset;
		if (gt_reset_o.cpll_reset || hold_lock_low) begin
			status.cpll_lock = 1'b0;
			lock_dly = 1 + {$random(seed)} % 8;
		end else if (lock_dly > 1)
			lock_dly--;
		else
			status.cpll_lock = 1'b1;
		mmcm_locked_i = !gt_reset_o.mmcm_reset;
		if (gt_reset_o.gt_txrx_reset) begin
			status.tx_reset_done = 1'b0;
			status.rx_reset_done = 1'b0;
			tx_dly = 1 + {$random(seed)} % 16;
			rx_dly = 1 + {$random(seed)} % 16;
		end else begin
			if (tx_dly > 1)
				tx_dly--;
			else
				status.tx_reset_done = 1'b1;
			if (rx_dly > 1)
				rx_dly--;
			else
				status.rx_reset_done = 1'b1;
		end
		status.rx_cdr_lock     = status.rx_reset_done;
		status.rx_byte_aligned = status.rx_reset_done;
		// two phase-done pulses once the rx delay reset drops
		if (dly_prev && !gt_reset_o.rx_dlysreset)
			ph_step = 1;
		else if (ph_step > 0)
			ph_step = (ph_step == 8) ? 0 : ph_step + 1;
		dly_prev = gt_reset_o.rx_dlysreset;
		status.rx_phalign_done = (ph_step == 3 || ph_step == 6);
		stb_cnt = (stb_cnt == 4) ? 0 : stb_cnt + 1;
		txphase_stb_i = (stb_cnt == 0);
		rx_sym_i = tx_sym_o; // loopback
	end

	task automatic report_mismatch(input string name, input logic [31:0] got,
	                               input logic [31:0] exp);
		$display("ERROR %s: got %h expected %h", name, got, exp);
		val_err++;
	endtask

	task automatic finish_run();
		$display("summary: %0d value errors, %0d other errors", val_err, other_err);
		if (val_err == 0 && other_err == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	endtask

	task automatic apply_reset(input bit check);
		reset = 1'b1;
		repeat (10) begin
			@(posedge clk);
			#2;
			if (check && gt_reset_o !== 5'b00000)
				report_mismatch("gt_reset_o", gt_reset_o, 5'b00000);
			if (check && link_up_o !== 1'b0)
				report_mismatch("link_up_o", link_up_o, 0);
			if (check && attempt_cnt_o !== 16'h0)
				report_mismatch("attempt_cnt_o", attempt_cnt_o, 0);
		end
		rise_cnt = 0;
		reset = 1'b0;
		if (check) begin
			@(posedge clk);
			#2;
			if (gt_reset_o !== 5'b11100)
				report_mismatch("gt_reset_o", gt_reset_o, 5'b11100);
		end
	endtask

	// waits for link up and tracks the alignment word order
	task automatic wait_link_up(input string what);
		int  n;
		bit  seen1, seen2, seen3;
		n = 0;
		seen1 = 0;
		seen2 = 0;
		seen3 = 0;
		while (!link_up_o && n < WAIT_MAX) begin
			@(posedge clk);
			#2;
			n++;
			if (tx_sym_o == ALIGN1_SYM)
				seen1 = 1;
			if (tx_sym_o == ALIGN2_SYM) begin
				if (!seen1) begin
					$display("ALIGN2_SYM sent before ALIGN1_SYM in the %s test", what);
					other_err++;
				end
				seen2 = 1;
			end
			if (tx_sym_o == ALIGN3_SYM) begin
				if (!seen2) begin
					$display("ALIGN3_SYM sent before ALIGN2_SYM in the %s test", what);
					other_err++;
				end
				seen3 = 1;
			end
		end
		if (!link_up_o) begin
			$display("timeout: link never came up in the %s test", what);
			other_err++;
		end else if (!seen3) begin
			$display("ALIGN3_SYM never sent before link up in the %s test", what);
			other_err++;
		end
	endtask

	task automatic wait_rises(input int count);
		int n;
		n = 0;
		while (rise_cnt < count && n < WAIT_MAX) begin
			@(posedge clk);
			#2;
			n++;
			if (link_up_o) begin
				$display("link came up while it should keep restarting");
				other_err++;
			end
		end
		if (rise_cnt < count) begin
			$display("timeout: cpll_reset did not reassert");
			other_err++;
		end
	endtask

	task automatic check_user_data();
		symbol_t prev;
		prev = rand_sym();
		user_sym_i = prev;
		repeat (16) begin
			@(posedge clk);
			#2;
			if (tx_sym_o !== prev)
				report_mismatch("tx_sym_o", tx_sym_o, prev);
			prev = rand_sym();
			user_sym_i = prev;
		end
	endtask

	initial begin
		int n;
		seed = 92083;
		val_err = 0;
		other_err = 0;
		rise_cnt = 0;
		cpll_prev = 0;
		dly_prev = 0;
		hold_lock_low = 0;
		lock_dly = 0;
		tx_dly = 0;
		rx_dly = 0;
		ph_step = 0;
		stb_cnt = 0;
		reset = 1'b1;
		status = '0;
		mmcm_locked_i = 1'b0;
		sfp_los_i = 1'b0;
		txphase_stb_i = 1'b0;
		bypass_txph_check_i = 1'b0;
		rx_sym_i = '0;
		user_sym_i = '0;
		txphase_i = $random(seed);
		txphase_target_i = scaled_phase(txphase_i);

		apply_reset(1);
		wait_link_up("normal");
		if (attempt_cnt_o !== 16'd1)
			report_mismatch("attempt_cnt_o", attempt_cnt_o, 1);
		check_user_data();

		// phase target off by one
		txphase_i = $random(seed);
		txphase_target_i = scaled_phase(txphase_i) + 1'b1;
		apply_reset(0);
		wait_rises(3);
		txphase_target_i = scaled_phase(txphase_i);
		wait_link_up("phase mismatch");
		if (attempt_cnt_o !== rise_cnt[15:0])
			report_mismatch("attempt_cnt_o", attempt_cnt_o, rise_cnt);

		bypass_txph_check_i = 1'b1;
		txphase_target_i = scaled_phase(txphase_i) + 1'b1;
		apply_reset(0);
		wait_link_up("bypass");
		if (attempt_cnt_o !== 16'd1)
			report_mismatch("attempt_cnt_o", attempt_cnt_o, 1);
		bypass_txph_check_i = 1'b0;
		txphase_target_i = scaled_phase(txphase_i);

		// pll never locks, timeout restarts
		hold_lock_low = 1'b1;
		apply_reset(0);
		wait_rises(2);
		hold_lock_low = 1'b0;
		wait_link_up("pll timeout");
		if (attempt_cnt_o < 16'd2 || attempt_cnt_o !== rise_cnt[15:0])
			report_mismatch("attempt_cnt_o", attempt_cnt_o, rise_cnt);

		rise_cnt = 0;
		hold_lock_low = 1'b1;
		n = 0;
		while (link_up_o && n < WAIT_MAX) begin
			@(posedge clk);
			#2;
			n++;
		end
		if (link_up_o) begin
			$display("timeout: link stayed up after pll lock loss");
			other_err++;
		end
		if (gt_reset_o.cpll_reset !== 1'b1)
			report_mismatch("gt_reset_o.cpll_reset", gt_reset_o.cpll_reset, 1);
		hold_lock_low = 1'b0;
		wait_link_up("loss in data");
		if (attempt_cnt_o !== rise_cnt[15:0])
			report_mismatch("attempt_cnt_o", attempt_cnt_o, rise_cnt);

		finish_run();
	end

endmodule

// ==== verif/gt_bringup_assertions.sv ====
`timescale 1ns/1ps

module gt_bringup_assertions
	import gt_bringup_pkg::*;
(
	input logic      clk,
	input logic      reset,
	input gt_reset_t gt_reset_o,
	input logic      link_up_o
);

	// link is only up with every reset released
	property link_up_clean;
		@(posedge clk) disable iff (reset)
			link_up_o |-> (gt_reset_o == '0);
	endproperty

	// the two delay aligners are reset one after the other
	property dlysreset_exclusive;
		@(posedge clk) disable iff (reset)
			!(gt_reset_o.tx_dlysreset && gt_reset_o.rx_dlysreset);
	endproperty

	a_link_up_clean: assert property (link_up_clean)
		else $error("link_up_o high while a reset output is set");

	a_dlysreset_exclusive: assert property (dlysreset_exclusive)
		else $error("tx and rx delay resets asserted together");

endmodule

bind bringup_sequencer gt_bringup_assertions u_gt_bringup_assertions (
	.clk        (clk),
	.reset      (reset),
	.gt_reset_o (gt_reset_o),
	.link_up_o  (link_up_o)
);

// ==== rtl/gt_bringup_top.sv ====
`timescale 1ns/1ps

module gt_bringup_top
	import gt_bringup_pkg::*;
#(
	parameter int unsigned WAIT_CYCLES       = 200,
	parameter int unsigned TIMEOUT_SHORT     = 32'h0400_0000,
	parameter int unsigned TIMEOUT_LONG      = 32'hc000_0000,
	parameter int unsigned CDR_STABLE_CYCLES = 32'h00ff_ffff,
	parameter int unsigned ALIGN_HOLD        = 100,
	parameter int          LOCK_MAX          = 3
) (
	input  logic               clk,
	input  logic               reset,
	input  gt_status_t         gt_status_i,
	input  logic               mmcm_locked_i,
	input  logic               sfp_los_i,
	input  logic               txphase_stb_i,
	input  logic               bypass_txph_check_i,
	input  logic [15:0]        txphase_i,
	input  logic [PHASE_W-1:0] txphase_target_i,
	input  symbol_t            rx_sym_i,
	input  symbol_t            user_sym_i,
	output gt_reset_t          gt_reset_o,
	output symbol_t            tx_sym_o,
	output logic               link_up_o,
	output logic [15:0]        attempt_cnt_o
);

	logic     cdr_locked;
	logic     rx_phalign_ok;
	logic     txph_good;
	logic     farend_align2;
	tx_word_e tx_sel;

	cdr_lock_filter #(.LOCK_MAX(LOCK_MAX)) u_cdr_lock_filter (
		.clk            (clk),
		.reset          (reset),
		.cdr_lock_raw_i (gt_status_i.rx_cdr_lock),
		.cdr_locked_o   (cdr_locked)
	);

	// watches our own rx delay reset
	rx_phalign_detect u_rx_phalign_detect (
		.clk              (clk),
		.reset            (reset),
		.dlysreset_i      (gt_reset_o.rx_dlysreset),
		.dlysreset_done_i (gt_status_i.rx_dlysreset_done),
		.phalign_done_i   (gt_status_i.rx_phalign_done),
		.phalign_ok_o     (rx_phalign_ok)
	);

	tx_phase_check u_tx_phase_check (
		.clk              (clk),
		.txphase_i        (txphase_i),
		.txphase_target_i (txphase_target_i),
		.bypass_i         (bypass_txph_check_i),
		.txph_good_o      (txph_good)
	);

	align_word_codec u_align_word_codec (
		.clk             (clk),
		.reset           (reset),
		.tx_sel_i        (tx_sel),
		.user_sym_i      (user_sym_i),
		.rx_sym_i        (rx_sym_i),
		.tx_sym_o        (tx_sym_o),
		.farend_align2_o (farend_align2)
	);

	bringup_sequencer #(
		.WAIT_CYCLES       (WAIT_CYCLES),
		.TIMEOUT_SHORT     (TIMEOUT_SHORT),
		.TIMEOUT_LONG      (TIMEOUT_LONG),
		.CDR_STABLE_CYCLES (CDR_STABLE_CYCLES),
		.ALIGN_HOLD        (ALIGN_HOLD)
	) u_bringup_sequencer (
		.clk             (clk),
		.reset           (reset),
		.gt_status_i     (gt_status_i),
		.mmcm_locked_i   (mmcm_locked_i),
		.sfp_los_i       (sfp_los_i),
		.txphase_stb_i   (txphase_stb_i),
		.cdr_locked_i    (cdr_locked),
		.rx_phalign_ok_i (rx_phalign_ok),
		.txph_good_i     (txph_good),
		.farend_align2_i (farend_align2),
		.gt_reset_o      (gt_reset_o),
		.tx_sel_o        (tx_sel),
		.link_up_o       (link_up_o),
		.attempt_cnt_o   (attempt_cnt_o)
	);

endmodule

// ==== rtl/bringup_sequencer.sv ====
`timescale 1ns/1ps

module bringup_sequencer
	import gt_bringup_pkg::*;
#(
	parameter int unsigned WAIT_CYCLES       = 200,
	parameter int unsigned TIMEOUT_SHORT     = 32'h0400_0000,
	parameter int unsigned TIMEOUT_LONG      = 32'hc000_0000,
	parameter int unsigned CDR_STABLE_CYCLES = 32'h00ff_ffff,
	parameter int unsigned ALIGN_HOLD        = 100
) (
	input  logic        clk,
	input  logic        reset,
	input  gt_status_t  gt_status_i,
	input  logic        mmcm_locked_i,
	input  logic        sfp_los_i,
	input  logic        txphase_stb_i,
	input  logic        cdr_locked_i,
	input  logic        rx_phalign_ok_i,
	input  logic        txph_good_i,
	input  logic        farend_align2_i,
	output gt_reset_t   gt_reset_o,
	output tx_word_e    tx_sel_o,
	output logic        link_up_o,
	output logic [15:0] attempt_cnt_o
);

	localparam int unsigned CPLL_HOLD = 2;
	localparam int unsigned DLY_HOLD  = 5; // delay-aligner reset pulse

	bringup_state_e state, next;
	logic [31:0]    cnt;
	logic [15:0]    attempt;
	logic           farend_seen;
	logic           tmo, tmo_long;
	logic           pll_ok;

	assign tmo      = (cnt == TIMEOUT_SHORT);
	assign tmo_long = (cnt == TIMEOUT_LONG);
	assign pll_ok   = gt_status_i.cpll_lock & ~gt_status_i.cpll_fbclk_lost &
	                  ~gt_status_i.cpll_refclk_lost;

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= IDLE;
			cnt   <= '0;
		end else begin
			state <= next;
			cnt   <= (next == state) ? cnt + 1'b1 : '0;
		end
	end

	always_comb begin
		next = state;
		case (state)
			IDLE:       next = TX_WAIT;
			TX_WAIT:    next = tmo ? TX_TMO : (cnt == WAIT_CYCLES) ? CPLL_RESET : TX_WAIT;
			CPLL_RESET: next = tmo ? TX_TMO : (cnt == CPLL_HOLD) ? CPLL_WAIT : CPLL_RESET;
			CPLL_WAIT:  next = tmo ? TX_TMO : gt_status_i.cpll_lock ? MMCM_WAIT : CPLL_WAIT;
			MMCM_WAIT:  next = tmo ? TX_TMO : mmcm_locked_i ? TXRX_RESET : MMCM_WAIT;
			TXRX_RESET: next = tmo ? TX_TMO : (cnt == ALIGN_HOLD) ? TXRX_WAIT : TXRX_RESET;
			TXRX_WAIT: begin
				if (tmo_long)
					next = TX_TMO;
				else if (gt_status_i.tx_reset_done)
					next = TX_DONE;
				else if (gt_status_i.rx_reset_done)
					next = RX_DONE;
			end
			TX_DONE: next = tmo ? TX_TMO : !pll_ok ? TX_WAIT :
			                gt_status_i.rx_reset_done ? TXRX_DONE : TX_DONE;
			RX_DONE: next = tmo ? TX_TMO : !pll_ok ? TX_WAIT :
			                gt_status_i.tx_reset_done ? TXRX_DONE : RX_DONE;
			TXRX_DONE: begin
				if (tmo_long)
					next = RX_TMO;
				else if (pll_ok && gt_status_i.tx_reset_done && gt_status_i.rx_reset_done)
					next = TX_DLYSRESET;
				else
					next = TX_WAIT;
			end
			TX_DLYSRESET:    next = (cnt == DLY_HOLD) ? TX_DLYSRESET_D1 : TX_DLYSRESET;
			TX_DLYSRESET_D1: next = TXPH_STB1; // tx phase-done not checked
			// second strobe carries a settled phase sample
			TXPH_STB1:  next = tmo ? TX_TMO : txphase_stb_i ? TXPH_STB2 : TXPH_STB1;
			TXPH_STB2:  next = tmo ? TX_TMO : txphase_stb_i ? TXPH_CHECK : TXPH_STB2;
			TXPH_CHECK: next = txph_good_i ? RX_WAIT : TX_WAIT;
			RX_WAIT: next = !txph_good_i ? TX_WAIT :
			                (cnt == WAIT_CYCLES) ? RX_CDR_RDY : RX_WAIT;
			RX_CDR_RDY: next = tmo ? RX_TMO : !txph_good_i ? TX_WAIT :
			                   (cdr_locked_i && !sfp_los_i) ? RX_CDR_STABLE : RX_CDR_RDY;
			RX_CDR_STABLE: begin
				if (!txph_good_i)
					next = TX_WAIT;
				else if (!cdr_locked_i || sfp_los_i)
					next = RX_CDR_RDY; // lock wobbled, start the hold again
				else if (cnt == CDR_STABLE_CYCLES)
					next = RX_DLYSRESET;
			end
			RX_DLYSRESET: next = tmo ? RX_TMO : !txph_good_i ? TX_WAIT :
			                     (cnt == DLY_HOLD) ? RX_DLYSRESET_D1 : RX_DLYSRESET;
			RX_DLYSRESET_D1: next = tmo ? RX_TMO : !txph_good_i ? TX_WAIT :
			                        rx_phalign_ok_i ? ALIGN1 : RX_DLYSRESET_D1;
			ALIGN1: next = tmo ? RX_TMO : !cdr_locked_i ? RX_WAIT :
			               gt_status_i.rx_byte_aligned ? ALIGN2 : ALIGN1;
			ALIGN2: next = tmo ? RX_TMO : !cdr_locked_i ? RX_WAIT :
			               !gt_status_i.rx_byte_aligned ? ALIGN1 :
			               (cnt == ALIGN_HOLD) ? ALIGN2_CHK : ALIGN2;
			ALIGN2_CHK: next = tmo ? RX_TMO : !cdr_locked_i ? RX_WAIT :
			                   !gt_status_i.rx_byte_aligned ? ALIGN1 :
			                   farend_seen ? ALIGN3 : ALIGN2;
			ALIGN3: next = tmo ? RX_TMO : !cdr_locked_i ? RX_WAIT :
			               !gt_status_i.rx_byte_aligned ? ALIGN1 :
			               (cnt == ALIGN_HOLD) ? DATA : ALIGN3;
			DATA: next = (!pll_ok || !mmcm_locked_i || !txph_good_i) ? TX_WAIT : DATA;
			TX_TMO:  next = TX_WAIT;
			RX_TMO:  next = TX_WAIT;
			default: next = TX_WAIT;
		endcase
	end

	// outputs follow next so they line up with the state
	always_ff @(posedge clk) begin
		if (reset) begin
			gt_reset_o    <= '0;
			tx_sel_o      <= TXW_ALIGN1;
			link_up_o     <= 1'b0;
			attempt_cnt_o <= '0;
			attempt       <= '0;
			farend_seen   <= 1'b0;
		end else begin
			link_up_o <= (next == DATA);
			if (next == CPLL_RESET && state != CPLL_RESET)
				attempt <= attempt + 1'b1;
			if (next == DATA && state != DATA) begin
				attempt_cnt_o <= attempt; // report and start over
				attempt       <= '0;
			end
			case (next)
				TX_WAIT: begin
					gt_reset_o <= '{cpll_reset: 1'b1, mmcm_reset: 1'b1,
					                gt_txrx_reset: 1'b1, default: 1'b0};
					tx_sel_o   <= TXW_ALIGN1;
				end
				CPLL_RESET:      gt_reset_o.cpll_reset <= 1'b1;
				CPLL_WAIT:       gt_reset_o.cpll_reset <= 1'b0;
				MMCM_WAIT: begin
					gt_reset_o.mmcm_reset    <= 1'b0;
					gt_reset_o.gt_txrx_reset <= 1'b0;
				end
				TXRX_RESET:      gt_reset_o.gt_txrx_reset <= 1'b1;
				TXRX_WAIT, TX_DONE, RX_DONE, TXRX_DONE:
					gt_reset_o.gt_txrx_reset <= 1'b0;
				TX_DLYSRESET: begin
					gt_reset_o.tx_dlysreset <= 1'b1;
					farend_seen             <= 1'b0;
				end
				TX_DLYSRESET_D1: gt_reset_o.tx_dlysreset <= 1'b0;
				RX_WAIT:         tx_sel_o <= TXW_ALIGN1;
				RX_DLYSRESET:    gt_reset_o.rx_dlysreset <= 1'b1;
				RX_DLYSRESET_D1: gt_reset_o.rx_dlysreset <= 1'b0;
				ALIGN1: begin
					tx_sel_o <= TXW_ALIGN1;
					if (farend_align2_i)
						farend_seen <= 1'b1;
				end
				ALIGN2, ALIGN2_CHK: begin
					tx_sel_o <= TXW_ALIGN2;
					if (farend_align2_i)
						farend_seen <= 1'b1;
				end
				ALIGN3:          tx_sel_o <= TXW_ALIGN3;
				DATA: begin
					tx_sel_o    <= TXW_USER;
					farend_seen <= 1'b0;
				end
				default: ;
			endcase
		end
	end

endmodule

// ==== rtl/align_word_codec.sv ====
`timescale 1ns/1ps

module align_word_codec
	import gt_bringup_pkg::*;
(
	input  logic     clk,
	input  logic     reset,
	input  tx_word_e tx_sel_i,
	input  symbol_t  user_sym_i,
	input  symbol_t  rx_sym_i,
	output symbol_t  tx_sym_o,
	output logic     farend_align2_o
);

	symbol_t tx_sym_next;

	// outgoing word mux
	always_comb begin
		case (tx_sel_i)
			TXW_ALIGN1: tx_sym_next = ALIGN1_SYM;
			TXW_ALIGN2: tx_sym_next = ALIGN2_SYM;
			TXW_ALIGN3: tx_sym_next = ALIGN3_SYM;
			default:    tx_sym_next = user_sym_i; // TXW_USER
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset)
			tx_sym_o <= ALIGN1_SYM; // idle on the first word
		else
			tx_sym_o <= tx_sym_next;
	end

	// far end in its second handshake step
	assign farend_align2_o = (rx_sym_i == ALIGN2_SYM);

endmodule

// ==== rtl/tx_phase_check.sv ====
`timescale 1ns/1ps

module tx_phase_check
	import gt_bringup_pkg::*;
(
	input  logic               clk,
	input  logic [15:0]        txphase_i,
	input  logic [PHASE_W-1:0] txphase_target_i,
	input  logic               bypass_i,
	output logic               txph_good_o
);

	logic [13:0]        phase14;
	logic [16:0]        phase_x5;
	logic [PHASE_W-1:0] phase_scaled;

	assign phase14 = txphase_i[13:0];

	// x5 as shift plus add, top bits give the coarse phase
	assign phase_x5     = ({3'b000, phase14} << 2) + {3'b000, phase14};
	assign phase_scaled = phase_x5[16 -: PHASE_W];

	always_ff @(posedge clk) begin
		txph_good_o <= bypass_i | (phase_scaled == txphase_target_i);
	end

endmodule

// ==== rtl/rx_phalign_detect.sv ====
`timescale 1ns/1ps

module rx_phalign_detect (
	input  logic clk,
	input  logic reset,
	input  logic dlysreset_i,
	input  logic dlysreset_done_i,
	input  logic phalign_done_i,
	output logic phalign_ok_o
);

	logic phalign_d;   // previous phalign_done_i
	logic first_pend;  // still waiting for the first edge
	logic phalign_rise;

	assign phalign_rise = phalign_done_i & ~phalign_d;

	always_ff @(posedge clk) begin
		if (reset) begin
			phalign_d    <= 1'b0;
			first_pend   <= 1'b0;
			phalign_ok_o <= 1'b0;
		end else begin
			phalign_d <= phalign_done_i;
			if (dlysreset_i | dlysreset_done_i) begin
				first_pend   <= 1'b1; // re-arm
				phalign_ok_o <= 1'b0;
			end else if (phalign_rise) begin
				first_pend <= 1'b0;
				// first edge is the coarse pass, second one counts
				if (!first_pend)
					phalign_ok_o <= 1'b1;
			end
		end
	end

endmodule

// ==== rtl/cdr_lock_filter.sv ====
`timescale 1ns/1ps

module cdr_lock_filter #(
	parameter int LOCK_MAX = 3
) (
	input  logic clk,
	input  logic reset,
	input  logic cdr_lock_raw_i,
	output logic cdr_locked_o
);

	localparam int CNT_W = $clog2(LOCK_MAX) + 1;
	localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(LOCK_MAX - 1);

	logic [CNT_W-1:0] unlock_cnt; // consecutive unlocked cycles

	always_ff @(posedge clk) begin
		if (reset) begin
			unlock_cnt   <= '0;
			cdr_locked_o <= 1'b0;
		end else if (cdr_lock_raw_i) begin
			unlock_cnt   <= '0; // one good cycle is enough
			cdr_locked_o <= 1'b1;
		end else if (unlock_cnt == CNT_LAST) begin
			// held unlocked long enough, drop the level
			cdr_locked_o <= 1'b0;
		end else begin
			unlock_cnt <= unlock_cnt + 1'b1;
		end
	end

endmodule

// ==== rtl/gt_bringup_pkg.sv ====
package gt_bringup_pkg;

	localparam int PHASE_W = 5; // scaled transmit phase width

	// transceiver status levels
	typedef struct packed {
		logic cpll_lock;
		logic cpll_fbclk_lost;
		logic cpll_refclk_lost;
		logic tx_reset_done;
		logic rx_reset_done;
		logic rx_cdr_lock;
		logic rx_byte_aligned;
		logic rx_phalign_done;
		logic rx_dlysreset_done;
	} gt_status_t;

	// reset controls toward the transceiver
	typedef struct packed {
		logic cpll_reset;
		logic mmcm_reset;
		logic gt_txrx_reset; // drives both tx and rx resets
		logic tx_dlysreset;
		logic rx_dlysreset;
	} gt_reset_t;

	// one 16-bit 8b/10b word with its k flags
	typedef struct packed {
		logic [15:0] data;
		logic [1:0]  charisk;
	} symbol_t;

	typedef enum logic [1:0] {
		TXW_ALIGN1,
		TXW_ALIGN2,
		TXW_ALIGN3,
		TXW_USER
	} tx_word_e;

	typedef enum logic [4:0] {
		IDLE, TX_WAIT, CPLL_RESET, CPLL_WAIT, MMCM_WAIT,
		TXRX_RESET, TXRX_WAIT, TX_DONE, RX_DONE, TXRX_DONE,
		TX_DLYSRESET, TX_DLYSRESET_D1, TXPH_STB1, TXPH_STB2, TXPH_CHECK,
		RX_WAIT, RX_CDR_RDY, RX_CDR_STABLE, RX_DLYSRESET, RX_DLYSRESET_D1,
		ALIGN1, ALIGN2, ALIGN2_CHK, ALIGN3, DATA,
		TX_TMO, RX_TMO
	} bringup_state_e;

	// alignment words, K28.5 in the low byte
	localparam symbol_t ALIGN1_SYM = '{data: 16'h01bc, charisk: 2'b01};
	localparam symbol_t ALIGN2_SYM = '{data: 16'h02bc, charisk: 2'b01};
	localparam symbol_t ALIGN3_SYM = '{data: 16'h03bc, charisk: 2'b01};

endpackage
